// File: cache_geom_pkg.sv
package cache_geom_pkg;

   // address split into tag [31:6], index [5:3], word select [2] and byte [1:0]
   localparam int TAG_W        = 26;
   localparam int INDEX_W      = 3;
   localparam int TAG_LSB      = 6;
   localparam int INDEX_LSB    = 3;
   localparam int WORD_SEL_BIT = 2;

   // two ways of eight sets, two words per block
   localparam int NUM_SETS = 8;
   localparam int NUM_WAYS = 2;

   typedef logic [31:0]        word_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;

   // one block of one way
   typedef struct packed {
      tag_t            tag;
      logic            valid;
      logic            dirty;
      word_t [1:0]     data;
   } line_t;

   // lru holds the way that was used last
   typedef struct packed {
      line_t [NUM_WAYS-1:0] way;
      logic                 lru;
   } set_t;

endpackage

// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

   // miss and flush controller states
   typedef enum logic [3:0] {
      IDLE,
      WB0,
      WB1,
      FILL0,
      FILL1,
      SWEEP,
      FLUSH0,
      FLUSH1,
      HALTED
   } ctrl_state_t;

   // what the memory port drives this cycle
   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_WRITE,
      MEM_READ
   } mem_op_t;

endpackage

// File: line_store_if.sv
interface line_store_if;

   // contents of the selected set
   cache_geom_pkg::set_t    cur_set;

   // request side, from the lookup
   cache_geom_pkg::index_t  req_index;
   cache_geom_pkg::tag_t    req_tag;
   logic                    hit_wr;
   logic                    hit_way;
   logic                    hit_word;
   cache_geom_pkg::word_t   hit_data;
   logic                    hit_lru;
   logic                    miss;

   // controller side
   logic                    idle;
   logic                    sweep_active;
   cache_geom_pkg::index_t  sweep_index;
   logic                    fill_wr;
   logic                    fill_way;
   logic                    fill_word;
   cache_geom_pkg::word_t   fill_data;
   logic                    fill_done;
   logic                    clean_wr;
   logic                    cur_way;
   logic                    cur_word;
   cache_ctrl_pkg::mem_op_t mem_op;

   modport store (
      output cur_set,
      input  req_index, req_tag, hit_wr, hit_way, hit_word, hit_data, hit_lru,
      input  sweep_active, sweep_index, fill_wr, fill_way, fill_word, fill_data,
      input  fill_done, clean_wr, cur_way
   );

   modport lookup (
      input  cur_set, idle,
      output req_index, req_tag, hit_wr, hit_way, hit_word, hit_data, hit_lru, miss
   );

   modport ctrl (
      input  cur_set, miss,
      output idle, sweep_active, sweep_index, fill_wr, fill_way, fill_word, fill_data,
      output fill_done, clean_wr, cur_way, cur_word, mem_op
   );

   modport port (
      input  cur_set, req_index, sweep_active, sweep_index, cur_way, cur_word, mem_op
   );

endinterface

// File: line_store.sv
module line_store (
   input logic         CLK,
   input logic         nRST,
   line_store_if.store st
);

   // all sets of the cache
   cache_geom_pkg::set_t   sets [cache_geom_pkg::NUM_SETS];

   // set selected for reads and writes this cycle
   cache_geom_pkg::index_t sel_index;

   // the sweep owns the index while the cache flushes
   assign sel_index = st.sweep_active ? st.sweep_index : st.req_index;

   // read side is purely combinational
   assign st.cur_set = sets[sel_index];

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         // every line invalid, clean, lru pointing at way 0
         for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++)
         begin
            sets[s] <= '0;
         end
      end
      else
      begin
         // processor store that hit
         if (st.hit_wr)
         begin
            sets[sel_index].way[st.hit_way].data[st.hit_word] <= st.hit_data;
            sets[sel_index].way[st.hit_way].dirty <= 1'b1;
         end

         // hit of either kind marks the way as used last
         if (st.hit_lru)
         begin
            sets[sel_index].lru <= st.hit_way;
         end

         // refill word from memory
         if (st.fill_wr)
         begin
            sets[sel_index].way[st.fill_way].data[st.fill_word] <= st.fill_data;
         end

         // last refill word hands the block to the request tag
         if (st.fill_done)
         begin
            sets[sel_index].way[st.fill_way].tag   <= st.req_tag;
            sets[sel_index].way[st.fill_way].valid <= 1'b1;
            sets[sel_index].way[st.fill_way].dirty <= 1'b0;
            sets[sel_index].lru                    <= st.fill_way;
         end

         // write-back or flush of this line finished
         if (st.clean_wr)
         begin
            sets[sel_index].way[st.cur_way].dirty <= 1'b0;
         end
      end
   end

endmodule

// File: req_lookup.sv
module req_lookup (
   input  logic                  dmemREN,
   input  logic                  dmemWEN,
   input  cache_geom_pkg::word_t dmemaddr,
   input  cache_geom_pkg::word_t dmemstore,
   output logic                  dhit,
   output cache_geom_pkg::word_t dmemload,
   line_store_if.lookup          lk
);

   cache_geom_pkg::tag_t   req_tag;
   logic                   word_sel;
   logic                   match0;
   logic                   match1;
   logic                   any_match;
   logic                   match_way;
   logic                   req;

   // address fields of the request
   assign req_tag      = dmemaddr[31:cache_geom_pkg::TAG_LSB];
   assign lk.req_index = dmemaddr[cache_geom_pkg::TAG_LSB-1:cache_geom_pkg::INDEX_LSB];
   assign lk.req_tag   = req_tag;
   assign word_sel     = dmemaddr[cache_geom_pkg::WORD_SEL_BIT];

   // tag compare against both valid ways
   assign match0    = lk.cur_set.way[0].valid && (lk.cur_set.way[0].tag == req_tag);
   assign match1    = lk.cur_set.way[1].valid && (lk.cur_set.way[1].tag == req_tag);
   assign any_match = match0 || match1;
   // at most one way can match
   assign match_way = match1;

   assign req = dmemREN || dmemWEN;

   // hits are only served while the controller sits in idle
   assign dhit    = lk.idle && req && any_match;
   assign lk.miss = lk.idle && req && !any_match;

   // read data is zero unless a read hit
   assign dmemload = (lk.idle && dmemREN && any_match)
                     ? lk.cur_set.way[match_way].data[word_sel] : '0;

   // store commits on the same edge as the hit
   assign lk.hit_wr   = lk.idle && dmemWEN && any_match;
   assign lk.hit_way  = match_way;
   assign lk.hit_word = word_sel;
   assign lk.hit_data = dmemstore;

   // lru follows every hit
   assign lk.hit_lru = dhit;

endmodule

// File: miss_ctrl.sv
module miss_ctrl (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  halt,
   input  logic                  dwait,
   input  cache_geom_pkg::word_t dload,
   output logic                  flushed,
   line_store_if.ctrl            ct
);

   cache_ctrl_pkg::ctrl_state_t state_q;
   cache_ctrl_pkg::ctrl_state_t state_d;
   logic [3:0]                  row_q;
   logic [3:0]                  row_d;
   logic                        last_row;
   logic                        victim_q;
   logic                        victim_d;
   cache_geom_pkg::line_t       victim_line;
   cache_geom_pkg::line_t       row_line;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state_q  <= cache_ctrl_pkg::IDLE;
         row_q    <= '0;
         victim_q <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         row_q    <= row_d;
         victim_q <= victim_d;
      end
   end

   // the victim is the way not used last
   assign victim_line = ct.cur_set.way[~ct.cur_set.lru];
   // line visited by the sweep with the way from the top row bit
   assign row_line    = ct.cur_set.way[row_q[cache_geom_pkg::INDEX_W]];
   // last of the sweep rows
   assign last_row = (row_q == 4'(cache_geom_pkg::NUM_SETS * cache_geom_pkg::NUM_WAYS - 1));

   assign ct.sweep_index = row_q[cache_geom_pkg::INDEX_W-1:0];
   assign ct.fill_data   = dload;
   assign ct.fill_way    = victim_q;
   assign ct.fill_word   = ct.cur_word;
   assign flushed        = (state_q == cache_ctrl_pkg::HALTED);
   assign ct.idle        = (state_q == cache_ctrl_pkg::IDLE);

   always_comb
   begin
      state_d         = state_q;
      row_d           = row_q;
      victim_d        = victim_q;
      ct.sweep_active = 1'b0;
      ct.fill_wr      = 1'b0;
      ct.fill_done    = 1'b0;
      ct.clean_wr     = 1'b0;
      ct.cur_way      = victim_q;
      ct.cur_word     = 1'b0;
      ct.mem_op       = cache_ctrl_pkg::MEM_NONE;

      case (state_q)
         cache_ctrl_pkg::IDLE:
         begin
            if (halt)
            begin
               row_d   = '0;
               state_d = cache_ctrl_pkg::SWEEP;
            end
            else if (ct.miss)
            begin
               victim_d = ~ct.cur_set.lru;
               // dirty victim goes back to memory before the refill
               if (victim_line.valid && victim_line.dirty)
                  state_d = cache_ctrl_pkg::WB0;
               else
                  state_d = cache_ctrl_pkg::FILL0;
            end
         end
         cache_ctrl_pkg::WB0, cache_ctrl_pkg::WB1:
         begin
            ct.mem_op   = cache_ctrl_pkg::MEM_WRITE;
            ct.cur_word = (state_q == cache_ctrl_pkg::WB1);
            if (!dwait)
            begin
               if (state_q == cache_ctrl_pkg::WB0)
               begin
                  state_d = cache_ctrl_pkg::WB1;
               end
               else
               begin
                  ct.clean_wr = 1'b1;
                  state_d     = cache_ctrl_pkg::FILL0;
               end
            end
         end
         cache_ctrl_pkg::FILL0, cache_ctrl_pkg::FILL1:
         begin
            ct.mem_op   = cache_ctrl_pkg::MEM_READ;
            ct.cur_word = (state_q == cache_ctrl_pkg::FILL1);
            // dload is only valid in the dwait low cycle
            if (!dwait)
            begin
               ct.fill_wr = 1'b1;
               if (state_q == cache_ctrl_pkg::FILL0)
               begin
                  state_d = cache_ctrl_pkg::FILL1;
               end
               else
               begin
                  ct.fill_done = 1'b1;
                  state_d      = cache_ctrl_pkg::IDLE;
               end
            end
         end
         cache_ctrl_pkg::SWEEP:
         begin
            ct.sweep_active = 1'b1;
            ct.cur_way      = row_q[cache_geom_pkg::INDEX_W];
            if (row_line.valid && row_line.dirty)
               state_d = cache_ctrl_pkg::FLUSH0;
            else if (last_row)
               state_d = cache_ctrl_pkg::HALTED;
            else
               row_d = row_q + 4'd1;
         end
         cache_ctrl_pkg::FLUSH0, cache_ctrl_pkg::FLUSH1:
         begin
            ct.sweep_active = 1'b1;
            ct.cur_way      = row_q[cache_geom_pkg::INDEX_W];
            ct.mem_op       = cache_ctrl_pkg::MEM_WRITE;
            ct.cur_word     = (state_q == cache_ctrl_pkg::FLUSH1);
            if (!dwait)
            begin
               if (state_q == cache_ctrl_pkg::FLUSH0)
               begin
                  state_d = cache_ctrl_pkg::FLUSH1;
               end
               else
               begin
                  // row done so move on or finish
                  ct.clean_wr = 1'b1;
                  if (last_row)
                  begin
                     state_d = cache_ctrl_pkg::HALTED;
                  end
                  else
                  begin
                     row_d   = row_q + 4'd1;
                     state_d = cache_ctrl_pkg::SWEEP;
                  end
               end
            end
         end
         // halted until reset
         default:
         begin
            state_d = cache_ctrl_pkg::HALTED;
         end
      endcase
   end

endmodule

// File: mem_port.sv
module mem_port (
   output logic                  dREN,
   output logic                  dWEN,
   output cache_geom_pkg::word_t daddr,
   output cache_geom_pkg::word_t dstore,
   input  cache_geom_pkg::word_t dmemaddr,
   line_store_if.port            mp
);

   cache_geom_pkg::index_t sel_index;
   cache_geom_pkg::line_t  line;

   // same index the store is reading from
   assign sel_index = mp.sweep_active ? mp.sweep_index : mp.req_index;
   // line under write-back or flush
   assign line      = mp.cur_set.way[mp.cur_way];

   always_comb
   begin
      dREN   = 1'b0;
      dWEN   = 1'b0;
      daddr  = '0;
      dstore = '0;

      case (mp.mem_op)
         cache_ctrl_pkg::MEM_WRITE:
         begin
            // address rebuilt from the stored tag, not the request
            dWEN   = 1'b1;
            daddr  = {line.tag, sel_index, mp.cur_word, 2'b00};
            dstore = line.data[mp.cur_word];
         end
         cache_ctrl_pkg::MEM_READ:
         begin
            // refill the block of the held request
            dREN  = 1'b1;
            daddr = {dmemaddr[31:cache_geom_pkg::WORD_SEL_BIT+1], mp.cur_word, 2'b00};
         end
         default:
         begin
            dREN = 1'b0;
         end
      endcase
   end

endmodule

// File: dcache_top.sv
module dcache_top (
   input  logic                  CLK,
   input  logic                  nRST,
   // processor side
   input  logic                  dmemREN,
   input  logic                  dmemWEN,
   input  cache_geom_pkg::word_t dmemaddr,
   input  cache_geom_pkg::word_t dmemstore,
   input  logic                  halt,
   output logic                  dhit,
   output cache_geom_pkg::word_t dmemload,
   output logic                  flushed,
   // memory side
   output logic                  dREN,
   output logic                  dWEN,
   output cache_geom_pkg::word_t daddr,
   output cache_geom_pkg::word_t dstore,
   input  cache_geom_pkg::word_t dload,
   input  logic                  dwait
);

   // set contents and write commands shared by all four blocks
   line_store_if lsif ();

   line_store i_line_store (
      .CLK  (CLK),
      .nRST (nRST),
      .st   (lsif.store)
   );

   req_lookup i_req_lookup (
      .dmemREN   (dmemREN),
      .dmemWEN   (dmemWEN),
      .dmemaddr  (dmemaddr),
      .dmemstore (dmemstore),
      .dhit      (dhit),
      .dmemload  (dmemload),
      .lk        (lsif.lookup)
   );

   miss_ctrl i_miss_ctrl (
      .CLK     (CLK),
      .nRST    (nRST),
      .halt    (halt),
      .dwait   (dwait),
      .dload   (dload),
      .flushed (flushed),
      .ct      (lsif.ctrl)
   );

   mem_port i_mem_port (
      .dREN     (dREN),
      .dWEN     (dWEN),
      .daddr    (daddr),
      .dstore   (dstore),
      .dmemaddr (dmemaddr),
      .mp       (lsif.port)
   );

endmodule

// File: dcache_sva.sv
module dcache_sva (
   input logic                  CLK,
   input logic                  nRST,
   input logic                  dREN,
   input logic                  dWEN,
   input logic                  dwait,
   input logic                  dhit,
   input logic                  flushed,
   input cache_geom_pkg::word_t daddr
);

   // one memory operation at a time
   no_read_write: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
      else $error("dREN and dWEN high in the same cycle");

   // a waiting word keeps its address
   addr_held: assert property (@(posedge CLK) disable iff (!nRST)
      (dwait && (dREN || dWEN)) |=> $stable(daddr))
      else $error("daddr changed while dwait was high");

   // no hits once the cache has flushed
   no_hit_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> !$rose(dhit))
      else $error("dhit rose after flushed");

endmodule

bind dcache_top dcache_sva i_dcache_sva (
   .CLK     (CLK),
   .nRST    (nRST),
   .dREN    (dREN),
   .dWEN    (dWEN),
   .dwait   (dwait),
   .dhit    (dhit),
   .flushed (flushed),
   .daddr   (daddr)
);

// File: tb_dcache.sv
module tb_dcache;

   // 36 word transfers over all tests, at most 4 cycles each, plus sweep and idle cycles
   localparam int          CYCLE_LIMIT = 4000;
   localparam int          MEM_WORDS   = 256;
   localparam logic [31:0] SEED        = 32'h6bc238b8;

   logic                  CLK;
   logic                  nRST;
   logic                  dmemREN;
   logic                  dmemWEN;
   logic                  halt;
   logic                  dhit;
   logic                  flushed;
   logic                  dREN;
   logic                  dWEN;
   logic                  dwait;
   cache_geom_pkg::word_t dmemaddr;
   cache_geom_pkg::word_t dmemstore;
   cache_geom_pkg::word_t dmemload;
   cache_geom_pkg::word_t daddr;
   cache_geom_pkg::word_t dstore;
   cache_geom_pkg::word_t dload;

   // memory model contents and the values the processor should see
   cache_geom_pkg::word_t mem     [MEM_WORDS];
   cache_geom_pkg::word_t ref_mem [MEM_WORDS];
   logic [31:0]           wait_rng;
   logic [31:0]           data_rng;
   int                    wait_left;
   logic                  busy;
   int                    cycles;
   int                    checks;
   int                    errors;
   // log of finished word transfers, in order
   logic                  xfer_is_write [$];
   cache_geom_pkg::word_t xfer_addr     [$];

   dcache_top i_dcache_top (
      .CLK       (CLK),
      .nRST      (nRST),
      .dmemREN   (dmemREN),
      .dmemWEN   (dmemWEN),
      .dmemaddr  (dmemaddr),
      .dmemstore (dmemstore),
      .halt      (halt),
      .dhit      (dhit),
      .dmemload  (dmemload),
      .flushed   (flushed),
      .dREN      (dREN),
      .dWEN      (dWEN),
      .daddr     (daddr),
      .dstore    (dstore),
      .dload     (dload),
      .dwait     (dwait)
   );

   always #5 CLK = ~CLK;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // initial memory word spread over the whole word index
   function automatic cache_geom_pkg::word_t fill_value(input int idx);
      return (32'(idx) * 32'h9e3779b1) ^ 32'h0000a5a5;
   endfunction

   function automatic cache_geom_pkg::word_t make_addr(input int tag, input int set, input int word);
      return 32'((tag << 6) | (set << 3) | (word << 2));
   endfunction

   function automatic int count_writes(input int from);
      int n;
      n = 0;
      for (int i = from; i < xfer_is_write.size(); i++)
      begin
         if (xfer_is_write[i])
            n++;
      end
      return n;
   endfunction

   // memory model decides dwait once the port outputs have settled
   always @(posedge CLK)
   begin
      #2;
      dload = '0;
      if (dREN || dWEN)
      begin
         // new word, draw 0 to 3 wait cycles
         if (!busy)
         begin
            busy      = 1'b1;
            wait_rng  = xorshift32(wait_rng);
            wait_left = int'(wait_rng[1:0]);
         end
         if (wait_left == 0)
         begin
            dwait = 1'b0;
            busy  = 1'b0;
            xfer_is_write.push_back(dWEN);
            xfer_addr.push_back(daddr);
            if (dWEN)
               mem[daddr[9:2]] = dstore;
            else
               dload = mem[daddr[9:2]];
         end
         else
         begin
            dwait     = 1'b1;
            wait_left = wait_left - 1;
         end
      end
      else
      begin
         dwait = 1'b1;
         busy  = 1'b0;
      end
   end

   // run limit
   always @(posedge CLK)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic check_value(input string name, input cache_geom_pkg::word_t got,
                              input cache_geom_pkg::word_t exp);
      checks = checks + 1;
      assert (got === exp)
      else
      begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         errors = errors + 1;
      end
   endtask

   // one processor request issued 1 unit after a rising edge
   task automatic access(input logic wr, input cache_geom_pkg::word_t addr,
                         input cache_geom_pkg::word_t wdata,
                         output cache_geom_pkg::word_t rdata, output int waited);
      dmemREN   = !wr;
      dmemWEN   = wr;
      dmemaddr  = addr;
      dmemstore = wdata;
      waited    = 0;
      #2;
      // held until dhit or until the run limit stops a stuck miss
      while (!dhit)
      begin
         @(posedge CLK);
         #3;
         waited++;
      end
      rdata = dmemload;
      if (wr)
         ref_mem[addr[9:2]] = wdata;
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
   endtask

   task automatic read_and_compare(input cache_geom_pkg::word_t addr, output int waited);
      cache_geom_pkg::word_t rdata;
      access(1'b0, addr, '0, rdata, waited);
      check_value("dmemload", rdata, ref_mem[addr[9:2]]);
   endtask

   task automatic store_word(input cache_geom_pkg::word_t addr, input cache_geom_pkg::word_t data,
                             output int waited);
      cache_geom_pkg::word_t rdata;
      access(1'b1, addr, data, rdata, waited);
   endtask

   task automatic report_test(input string name, input int e0);
      $display("%s: %s (%0d errors)", name, (errors == e0) ? "ok" : "failed", errors - e0);
   endtask

   task automatic read_miss_fill();
      int e0;
      int n0;
      int waited;
      e0 = errors;
      check_value("dREN after reset", 32'(dREN), 0);
      check_value("dWEN after reset", 32'(dWEN), 0);
      check_value("flushed after reset", 32'(flushed), 0);
      n0 = xfer_addr.size();
      read_and_compare(make_addr(1, 1, 0), waited);
      // empty set needs two refill words and no write-back
      check_value("refill transfers", 32'(xfer_addr.size() - n0), 2);
      check_value("write-back transfers", 32'(count_writes(n0)), 0);
      n0 = xfer_addr.size();
      read_and_compare(make_addr(1, 1, 1), waited);
      check_value("hit wait cycles", 32'(waited), 0);
      check_value("transfers on hit", 32'(xfer_addr.size() - n0), 0);
      report_test("read miss and refill", e0);
   endtask

   task automatic write_hit_store();
      int e0;
      int n0;
      int waited;
      e0 = errors;
      n0 = xfer_addr.size();
      store_word(make_addr(1, 1, 0), 32'h1234_5678, waited);
      check_value("hit wait cycles", 32'(waited), 0);
      check_value("dWEN transfers", 32'(count_writes(n0)), 0);
      read_and_compare(make_addr(1, 1, 0), waited);
      report_test("write hit", e0);
   endtask

   task automatic lru_eviction();
      int                    e0;
      int                    n0;
      int                    waited;
      cache_geom_pkg::word_t a;
      e0 = errors;
      // tag 2 lands in way 1, tag 3 in way 0
      read_and_compare(make_addr(2, 2, 0), waited);
      read_and_compare(make_addr(3, 2, 0), waited);
      store_word(make_addr(2, 2, 1), 32'hcafe_0001, waited);
      // way 0 used last, so the dirty tag 2 line is the victim
      read_and_compare(make_addr(3, 2, 1), waited);
      n0 = xfer_addr.size();
      read_and_compare(make_addr(4, 2, 0), waited);
      check_value("eviction transfers", 32'(xfer_addr.size() - n0), 4);
      check_value("first transfer dWEN", 32'(xfer_is_write[n0]), 1);
      check_value("second transfer dWEN", 32'(xfer_is_write[n0+1]), 1);
      check_value("first write-back daddr", xfer_addr[n0], make_addr(2, 2, 0));
      check_value("second write-back daddr", xfer_addr[n0+1], make_addr(2, 2, 1));
      check_value("third transfer dWEN", 32'(xfer_is_write[n0+2]), 0);
      check_value("fourth transfer dWEN", 32'(xfer_is_write[n0+3]), 0);
      a = make_addr(2, 2, 1);
      check_value("memory after write-back", mem[a[9:2]], ref_mem[a[9:2]]);
      n0 = xfer_addr.size();
      read_and_compare(make_addr(3, 2, 0), waited);
      check_value("hit wait cycles", 32'(waited), 0);
      check_value("transfers on hit", 32'(xfer_addr.size() - n0), 0);
      report_test("lru eviction", e0);
   endtask

   task automatic clean_victim_replace();
      int e0;
      int n0;
      int waited;
      e0 = errors;
      read_and_compare(make_addr(5, 3, 0), waited);
      read_and_compare(make_addr(6, 3, 0), waited);
      n0 = xfer_addr.size();
      // tag 5 is clean and least recently used
      read_and_compare(make_addr(7, 3, 1), waited);
      check_value("refill transfers", 32'(xfer_addr.size() - n0), 2);
      check_value("dWEN transfers", 32'(count_writes(n0)), 0);
      read_and_compare(make_addr(6, 3, 0), waited);
      check_value("hit wait cycles", 32'(waited), 0);
      report_test("clean victim", e0);
   endtask

   task automatic halt_flush();
      int                    e0;
      int                    waited;
      cache_geom_pkg::word_t d;
      e0 = errors;
      // mixed writes where the last one pushes a dirty line out of set 4
      data_rng = xorshift32(data_rng);
      store_word(make_addr(8, 4, 0), data_rng, waited);
      data_rng = xorshift32(data_rng);
      store_word(make_addr(9, 5, 1), data_rng, waited);
      data_rng = xorshift32(data_rng);
      store_word(make_addr(10, 4, 1), data_rng, waited);
      read_and_compare(make_addr(11, 6, 0), waited);
      data_rng = xorshift32(data_rng);
      store_word(make_addr(12, 4, 0), data_rng, waited);
      halt = 1'b1;
      #2;
      while (!flushed)
      begin
         @(posedge CLK);
         #3;
      end
      repeat (3) @(posedge CLK);
      #3;
      check_value("flushed held", 32'(flushed), 1);
      check_value("dWEN after flush", 32'(dWEN), 0);
      // every dirty word must now be in memory
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         d = mem[i];
         check_value($sformatf("memory word at %h", i * 4), d, ref_mem[i]);
      end
      // a read of a line still held in the cache gets no hit once halted
      @(posedge CLK);
      #1;
      dmemREN  = 1'b1;
      dmemaddr = make_addr(12, 4, 0);
      repeat (2) @(posedge CLK);
      #3;
      check_value("dhit after flush", 32'(dhit), 0);
      check_value("dREN after flush", 32'(dREN), 0);
      check_value("flushed with request", 32'(flushed), 1);
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      report_test("halt flush", e0);
   endtask

   initial
   begin
      CLK       = 1'b0;
      nRST      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      halt      = 1'b0;
      dload     = '0;
      dwait     = 1'b1;
      busy      = 1'b0;
      wait_left = 0;
      wait_rng  = SEED;
      data_rng  = SEED;
      cycles    = 0;
      checks    = 0;
      errors    = 0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem[i]     = fill_value(i);
         ref_mem[i] = fill_value(i);
      end
      repeat (10) @(posedge CLK);
      #1;
      nRST = 1'b1;
      @(posedge CLK);
      #1;
      read_miss_fill();
      write_hit_store();
      lru_eviction();
      clean_victim_replace();
      halt_flush();
      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: project.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
line_store_if.sv
line_store.sv
req_lookup.sv
miss_ctrl.sv
mem_port.sv
dcache_top.sv
dcache_sva.sv
tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f project.f -o sim_dcache
./obj_dir/sim_dcache > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
